//--- vlog.f
ps_pio_pkg.sv
cmd_deser.sv
status_generate.sv
cmd_fifo.sv
ps_pio_sequencer.sv
chn_rd_buf.sv
chn_wr_buf.sv
mcntrl_ps_pio.sv
tb_ps_pio.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_ps_pio -o tb_ps_pio \
    > build.log 2>&1 \
    && ./obj_dir/tb_ps_pio > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q '^Result: PASSED$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- tb_ps_pio.sv
/* directed testbench; both host ports run on the system clock
   the arbiter and sequencer are modelled by grant and done pulses */
`timescale 1ns/1ps
`default_nettype none
module tb_ps_pio;
    import ps_pio_pkg::*;
    localparam int          clk_period      = 8;
    localparam int          watchdog_cycles = 2000;  // tests need a few hundred
    localparam logic [15:0] addr_en         = 16'h100;
    localparam logic [15:0] addr_cmd        = 16'h101;
    localparam logic [15:0] addr_stat       = 16'h102;
    localparam logic [15:0] addr_outside    = 16'h202;  // fails the 0x3e0 mask
    localparam logic [7:0]  status_addr     = 8'h02;
    logic        rst, mclk, cmd_stb, status_rq, status_start;
    logic [7:0]  cmd_ad, status_ad;
    logic        port0_re, port0_regen, port1_we;
    logic [9:0]  port0_addr, port1_addr, seq_data0;
    logic [31:0] port0_data, port1_data;
    logic        want_rq0, need_rq0, want_rq1, need_rq1, channel_pgm_en0, channel_pgm_en1;
    logic        seq_set0, seq_done0, seq_done1, buf_wr_chn0, buf_waddr_rst_chn0;
    logic        buf_rd_chn1, buf_raddr_rst_chn1;
    logic [63:0] buf_wdata_chn0, buf_rdata_chn1;
    logic [63:0] words [4];   // channel 0 reference data
    logic [31:0] halves [8];  // channel 1 reference data
    integer      seed = 32'h0a9967b4;

    mcntrl_ps_pio i_mcntrl_ps_pio (.port0_clk(rst), .port1_clk(rst), .*);

    initial begin
        rst = 1'b0;
        forever #(clk_period / 2) rst = ~rst;
    end

    initial begin
        #(clk_period * watchdog_cycles);
        abort_run("timeout: the tests did not finish within the watchdog time");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic tick();  // inputs change 1 ns after the edge
        @(posedge rst);
        #1;
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s = %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_rqs(input logic [3:0] exp);  // want0 need0 want1 need1
        check_val("want_rq0,need_rq0,want_rq1,need_rq1",
                  64'({want_rq0, need_rq0, want_rq1, need_rq1}), 64'(exp));
    endtask

    function automatic logic [31:0] make_cmd(input logic chn, input logic need,
                                             input logic [1:0] page, input logic [9:0] seq_a);
        ps_cmd_data_u u;
        u = '0;
        u.cmd.entry = '{chn: chn, need: need, page: page, seq_a: seq_a};
        return u;
    endfunction

    function automatic logic [31:0] make_stat(input status_mode_t mode, input logic [5:0] seq);
        ps_cmd_data_u u;
        u = '0;
        u.stat.mode = mode;
        u.stat.seq  = seq;
        return u;
    endfunction

    function automatic logic [31:0] make_en(input logic en, input logic nrst);
        ps_cmd_data_u u;
        u = '0;
        u.enable.en   = en;
        u.enable.nrst = nrst;
        return u;
    endfunction

    task automatic send_cmd(input logic [15:0] a, input logic [31:0] d);
        logic [47:0] msg;
        msg = {d, a};  // addr lo goes first
        for (int i = 0; i < 6; i++) begin
            cmd_stb = (i == 0);
            cmd_ad  = msg[8*i +: 8];
            tick();
        end
        cmd_stb = 1'b0;
        cmd_ad  = 8'h00;
        tick();  // register write has landed
    endtask

    task automatic wait_rq(input int which);  // 0 want_rq0, 1 want_rq1, 2 status_rq
        int n;
        n = 0;
        while (!((which == 0 && want_rq0) || (which == 1 && want_rq1) ||
                 (which == 2 && status_rq))) begin
            if (n == 40) abort_run($sformatf("request %0d never came up", which));
            tick();
            n++;
        end
    endtask

    task automatic grant(input logic chn, input logic [9:0] exp_seq);
        channel_pgm_en0 = !chn;
        channel_pgm_en1 = chn;
        tick();
        channel_pgm_en0 = 1'b0;
        channel_pgm_en1 = 1'b0;
        check_rqs(4'b0000);
        check_val("seq_set0", 64'(seq_set0), 64'(1));
        check_val("seq_data0", 64'(seq_data0), 64'(exp_seq));
        tick();
        check_val("seq_set0", 64'(seq_set0), 64'(0));  // single pulse
    endtask

    task automatic done(input logic chn);
        seq_done0 = !chn;
        seq_done1 = chn;
        tick();
        seq_done0 = 1'b0;
        seq_done1 = 1'b0;
    endtask

    task automatic receive_status(input logic [5:0] seq, input logic [1:0] payload);
        wait_rq(2);
        check_val("status_ad", 64'(status_ad), 64'(status_addr));
        tick();  // not taken yet, byte must hold
        check_val("status_rq", 64'(status_rq), 64'(1));
        check_val("status_ad", 64'(status_ad), 64'(status_addr));
        status_start = 1'b1;
        tick();
        status_start = 1'b0;
        check_val("status_rq", 64'(status_rq), 64'(0));
        check_val("status_ad", 64'(status_ad), 64'({seq, payload}));
        tick();
        check_val("status_ad", 64'(status_ad), 64'(0));
    endtask

    task automatic test_decode_status();
        send_cmd(addr_outside, make_stat(mode_single, 6'h2a));
        repeat (6) begin
            tick();
            check_val("status_rq", 64'(status_rq), 64'(0));
        end
        send_cmd(addr_en, make_en(1'b1, 1'b1));
        send_cmd(addr_stat, make_stat(mode_single, 6'h2a));
        receive_status(6'h2a, 2'b00);  // idle queue
    endtask

    task automatic test_chn0_request();
        send_cmd(addr_cmd, make_cmd(1'b0, 1'b1, 2'd1, 10'h155));
        wait_rq(0);
        check_rqs(4'b1100);
        grant(1'b0, 10'h155);
        done(1'b0);
    endtask

    task automatic test_rd_buf(input logic [1:0] page);
        buf_waddr_rst_chn0 = 1'b1;
        tick();
        buf_waddr_rst_chn0 = 1'b0;
        for (int i = 0; i < 4; i++) begin
            words[i[1:0]]  = {$random(seed), $random(seed)};
            buf_wdata_chn0 = words[i[1:0]];
            buf_wr_chn0    = 1'b1;
            tick();
        end
        buf_wr_chn0 = 1'b0;
        for (int i = 0; i < 8; i++) begin
            port0_addr  = {page, i[7:1], i[0]};  // odd address is the high half
            port0_re    = 1'b1;
            tick();
            port0_re    = 1'b0;
            port0_regen = 1'b1;
            tick();
            port0_regen = 1'b0;
            check_val("port0_data", 64'(port0_data),
                      64'(i[0] ? words[i[2:1]][63:32] : words[i[2:1]][31:0]));
        end
    endtask

    task automatic test_chn1_queue();
        send_cmd(addr_cmd, make_cmd(1'b1, 1'b0, 2'd2, 10'h0a3));
        wait_rq(1);
        check_rqs(4'b0010);
        send_cmd(addr_cmd, make_cmd(1'b1, 1'b0, 2'd3, 10'h2c4));
        check_rqs(4'b0010);
        grant(1'b1, 10'h0a3);
        repeat (5) begin
            tick();
            check_rqs(4'b0000);  // second command waits for done
        end
        done(1'b1);
        wait_rq(1);
        check_rqs(4'b0010);
        grant(1'b1, 10'h2c4);
        done(1'b1);
    endtask

    task automatic test_wr_buf(input logic [1:0] page);
        for (int i = 0; i < 8; i++) begin
            halves[i[2:0]] = $random(seed);
            port1_addr     = {page, i[7:1], i[0]};
            port1_data     = halves[i[2:0]];
            port1_we       = 1'b1;
            tick();
        end
        port1_we           = 1'b0;
        buf_raddr_rst_chn1 = 1'b1;
        tick();
        buf_raddr_rst_chn1 = 1'b0;
        buf_rd_chn1        = 1'b1;
        for (int w = 0; w < 4; w++) begin
            tick();
            check_val("buf_rdata_chn1", buf_rdata_chn1,
                      {halves[{w[1:0], 1'b1}], halves[{w[1:0], 1'b0}]});
        end
        buf_rd_chn1 = 1'b0;
    endtask

    task automatic test_flush();
        send_cmd(addr_stat, make_stat(mode_auto, 6'h15));
        repeat (4) send_cmd(addr_cmd, make_cmd(1'b0, 1'b0, 2'd0, 10'h011));
        check_rqs(4'b1000);
        receive_status(6'h15, 2'b11);  // half full and pending
        send_cmd(addr_en, make_en(1'b1, 1'b0));
        tick();
        check_rqs(4'b0000);
        receive_status(6'h15, 2'b00);
    endtask

    initial begin
        {cmd_stb, cmd_ad, status_start} = '0;
        {port0_re, port0_regen, port0_addr, port1_we, port1_addr, port1_data} = '0;
        {channel_pgm_en0, channel_pgm_en1, seq_done0, seq_done1} = '0;
        {buf_wr_chn0, buf_waddr_rst_chn0, buf_wdata_chn0} = '0;
        {buf_rd_chn1, buf_raddr_rst_chn1} = '0;
        mclk = 1'b1;
        repeat (3) @(posedge rst);
        #1 mclk = 1'b0;
        tick();
        test_decode_status();
        test_chn0_request();
        test_rd_buf(2'd1);  // page latched by the chn 0 command
        test_chn1_queue();
        test_wr_buf(2'd3);
        test_flush();
        $display("Result: PASSED");
        $finish;
    end
endmodule
`default_nettype wire

//--- mcntrl_ps_pio.sv
/* pio channel pair; ddr3 sequencer, arbiter and phy sit outside
   seq_data0 and seq_set0 also serve channel 1 */
`timescale 1ns/1ps
`default_nettype none
module mcntrl_ps_pio #(
    parameter logic [15:0] cmd_addr        = 16'h100,
    parameter logic [15:0] cmd_mask        = 16'h3e0,  // covers both channels
    parameter logic [7:0]  status_reg_addr = 8'h2,
    parameter logic [ps_pio_pkg::reg_addr_width-1:0] reg_en_rst       = 'h0,
    parameter logic [ps_pio_pkg::reg_addr_width-1:0] reg_cmd          = 'h1,
    parameter logic [ps_pio_pkg::reg_addr_width-1:0] reg_status_cntrl = 'h2,
    parameter int          fifo_depth      = 4
) (
    input  logic        rst,
    input  logic        mclk,
    input  logic [7:0]  cmd_ad,        // AL, AH, D0..D3
    input  logic        cmd_stb,       // with the first byte
    output logic [7:0]  status_ad,
    output logic        status_rq,
    input  logic        status_start,
    input  logic        port0_clk,
    input  logic        port0_re,
    input  logic        port0_regen,
    input  logic [9:0]  port0_addr,    // includes page
    output logic [31:0] port0_data,
    input  logic        port1_clk,
    input  logic        port1_we,
    input  logic [9:0]  port1_addr,    // includes page
    input  logic [31:0] port1_data,
    output logic        want_rq0,
    output logic        need_rq0,
    input  logic        channel_pgm_en0,
    output logic [9:0]  seq_data0,     // sequencer address only
    output logic        seq_set0,
    input  logic        seq_done0,
    input  logic        buf_wr_chn0,
    input  logic        buf_waddr_rst_chn0,
    input  logic [63:0] buf_wdata_chn0,
    output logic        want_rq1,
    output logic        need_rq1,
    input  logic        channel_pgm_en1,
    input  logic        seq_done1,
    input  logic        buf_rd_chn1,
    input  logic        buf_raddr_rst_chn1,
    output logic [63:0] buf_rdata_chn1
);
    import ps_pio_pkg::*;
    logic [reg_addr_width-1:0]      cmd_a;
    ps_cmd_data_u                   cmd_data;
    logic                           cmd_we;
    logic                           fifo_we;
    logic                           fifo_flush;
    logic                           fifo_re;
    logic                           fifo_nempty;
    logic                           fifo_half_full;
    ps_cmd_entry_t                  fifo_head;
    logic                           status_we;
    logic [status_payload_bits-1:0] status_payload;
    logic [page_width-1:0]          page;
    cmd_deser #(.cmd_addr(cmd_addr), .cmd_mask(cmd_mask)) i_cmd_deser (
        .rst(rst), .mclk(mclk), .ad(cmd_ad), .stb(cmd_stb),
        .addr(cmd_a), .data(cmd_data), .we(cmd_we));
    ps_pio_sequencer #(
        .reg_en_rst(reg_en_rst), .reg_cmd(reg_cmd), .reg_status_cntrl(reg_status_cntrl)
    ) i_ps_pio_sequencer (
        .rst(rst), .mclk(mclk), .we(cmd_we), .addr(cmd_a), .data(cmd_data),
        .fifo_nempty(fifo_nempty), .fifo_half_full(fifo_half_full), .fifo_head(fifo_head),
        .channel_pgm_en0(channel_pgm_en0), .channel_pgm_en1(channel_pgm_en1),
        .seq_done0(seq_done0), .seq_done1(seq_done1),
        .fifo_we(fifo_we), .fifo_flush(fifo_flush), .fifo_re(fifo_re),
        .status_we(status_we), .status_payload(status_payload),
        .want_rq0(want_rq0), .need_rq0(need_rq0), .want_rq1(want_rq1), .need_rq1(need_rq1),
        .seq_data0(seq_data0), .seq_set0(seq_set0), .page(page));
    cmd_fifo #(.fifo_depth(fifo_depth)) i_cmd_fifo (
        .rst(rst), .mclk(mclk), .sync_rst(fifo_flush), .we(fifo_we), .re(fifo_re),
        .data_in(cmd_data.cmd.entry), .data_out(fifo_head),
        .nempty(fifo_nempty), .half_full(fifo_half_full));
    status_generate #(.status_reg_addr(status_reg_addr)) i_status_generate (
        .rst(rst), .mclk(mclk), .we(status_we), .wd(cmd_data), .status(status_payload),
        .ad(status_ad), .rq(status_rq), .start(status_start));
    chn_rd_buf i_chn_rd_buf (
        .rst(rst), .mclk(mclk), .page(page), .waddr_reset(buf_waddr_rst_chn0),
        .we(buf_wr_chn0), .data_in(buf_wdata_chn0), .ext_clk(port0_clk),
        .ext_raddr(port0_addr), .ext_rd(port0_re), .ext_regen(port0_regen),
        .ext_data_out(port0_data));
    chn_wr_buf i_chn_wr_buf (
        .ext_clk(port1_clk), .ext_waddr(port1_addr), .ext_we(port1_we),
        .ext_data_in(port1_data), .rst(rst), .mclk(mclk), .page(page),
        .raddr_reset(buf_raddr_rst_chn1), .rd(buf_rd_chn1), .data_out(buf_rdata_chn1));
endmodule
`default_nettype wire

//--- chn_wr_buf.sv
/* channel 1 buffer: 32-bit host writes, odd ext_waddr fills the high half
   data_out is valid one cycle after rd; the counter steps through the page */
`timescale 1ns/1ps
`default_nettype none
module chn_wr_buf (
    input  logic                              ext_clk,
    input  logic [9:0]                        ext_waddr,
    input  logic                              ext_we,
    input  logic [31:0]                       ext_data_in,
    input  logic                              rst,
    input  logic                              mclk,
    input  logic [ps_pio_pkg::page_width-1:0] page,
    input  logic                              raddr_reset,
    input  logic                              rd,
    output logic [63:0]                       data_out
);
    logic [31:0] mem_lo [512];  // even host addresses
    logic [31:0] mem_hi [512];  // odd host addresses
    logic [6:0]  rcnt;
    always_ff @(posedge ext_clk) begin
        if (ext_we && !ext_waddr[0]) mem_lo[ext_waddr[9:1]] <= ext_data_in;
        if (ext_we && ext_waddr[0])  mem_hi[ext_waddr[9:1]] <= ext_data_in;
    end
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk)             rcnt <= '0;
        else if (raddr_reset) rcnt <= '0;
        else if (rd)          rcnt <= rcnt + 7'd1;
    end
    always_ff @(posedge rst) begin
        if (rd) data_out <= {mem_hi[{page, rcnt}], mem_lo[{page, rcnt}]};
    end
endmodule
`default_nettype wire

//--- chn_rd_buf.sv
/* channel 0 buffer: 64-bit words from memory at {page, counter}, 32-bit host reads
   host read is ext_rd then ext_regen; even ext_raddr returns the low half */
`timescale 1ns/1ps
`default_nettype none
module chn_rd_buf (
    input  logic                              rst,
    input  logic                              mclk,
    input  logic [ps_pio_pkg::page_width-1:0] page,
    input  logic                              waddr_reset,
    input  logic                              we,
    input  logic [63:0]                       data_in,
    input  logic                              ext_clk,
    input  logic [9:0]                        ext_raddr,
    input  logic                              ext_rd,
    input  logic                              ext_regen,
    output logic [31:0]                       ext_data_out
);
    logic [63:0] mem [512];
    logic [6:0]  wcnt;     // word within the page
    logic [63:0] rd_word;  // first host read stage
    logic        rd_hi;
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk)             wcnt <= '0;
        else if (waddr_reset) wcnt <= '0;
        else if (we)          wcnt <= wcnt + 7'd1;
    end
    always_ff @(posedge rst) begin
        if (we) mem[{page, wcnt}] <= data_in;
    end
    always_ff @(posedge ext_clk) begin
        if (ext_rd) begin
            rd_word <= mem[ext_raddr[9:1]];
            rd_hi   <= ext_raddr[0];
        end
        if (ext_regen) ext_data_out <= rd_hi ? rd_word[63:32] : rd_word[31:0];
    end
endmodule
`default_nettype wire

//--- ps_pio_sequencer.sv
/* one command in flight at a time; mem_run holds off the next until seq_done
   seq_data0 and seq_set0 serve both channels */
`timescale 1ns/1ps
`default_nettype none
module ps_pio_sequencer #(
    parameter logic [ps_pio_pkg::reg_addr_width-1:0] reg_en_rst       = 'h0,
    parameter logic [ps_pio_pkg::reg_addr_width-1:0] reg_cmd          = 'h1,
    parameter logic [ps_pio_pkg::reg_addr_width-1:0] reg_status_cntrl = 'h2
) (
    input  logic                                       rst,
    input  logic                                       mclk,
    input  logic                                       we,
    input  logic [ps_pio_pkg::reg_addr_width-1:0]      addr,
    input  ps_pio_pkg::ps_cmd_data_u                   data,
    input  logic                                       fifo_nempty,
    input  logic                                       fifo_half_full,
    input  ps_pio_pkg::ps_cmd_entry_t                  fifo_head,
    input  logic                                       channel_pgm_en0,
    input  logic                                       channel_pgm_en1,
    input  logic                                       seq_done0,
    input  logic                                       seq_done1,
    output logic                                       fifo_we,
    output logic                                       fifo_flush,
    output logic                                       fifo_re,
    output logic                                       status_we,
    output logic [ps_pio_pkg::status_payload_bits-1:0] status_payload,
    output logic                                       want_rq0,
    output logic                                       need_rq0,
    output logic                                       want_rq1,
    output logic                                       need_rq1,
    output logic [ps_pio_pkg::seq_addr_width-1:0]      seq_data0,
    output logic                                       seq_set0,
    output logic [ps_pio_pkg::page_width-1:0]          page
);
    logic chn_en;    // new requests allowed
    logic chn_nrst;  // low holds queue and requests cleared
    logic mem_run;   // granted, transfer not done yet
    logic grant;
    logic busy;
    logic start;
    assign grant          = channel_pgm_en0 || channel_pgm_en1;
    assign busy           = want_rq0 || need_rq0 || want_rq1 || need_rq1 || mem_run;
    assign start          = chn_en && !busy && fifo_nempty;
    assign fifo_we        = we && (addr == reg_cmd);  // dropped by the queue when full
    assign status_we      = we && (addr == reg_status_cntrl);
    assign fifo_flush     = !chn_nrst;
    assign fifo_re        = seq_set0;  // pop as the sequencer takes the address
    assign seq_data0      = fifo_head.seq_a;
    assign status_payload = {fifo_half_full, fifo_nempty | busy};
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            {chn_en, chn_nrst, mem_run, seq_set0} <= '0;
            {want_rq0, need_rq0, want_rq1, need_rq1} <= '0;
            page <= '0;
        end else begin
            if (we && addr == reg_en_rst) begin
                chn_en   <= data.enable.en;
                chn_nrst <= data.enable.nrst;
            end
            if (!chn_nrst || grant) begin
                {want_rq0, need_rq0, want_rq1, need_rq1} <= '0;
            end else if (start) begin
                want_rq0 <= !fifo_head.chn;
                need_rq0 <= !fifo_head.chn && fifo_head.need;
                want_rq1 <= fifo_head.chn;
                need_rq1 <= fifo_head.chn && fifo_head.need;
            end
            if (seq_done0 || seq_done1) mem_run <= 1'b0;
            else if (grant)             mem_run <= 1'b1;
            seq_set0 <= chn_nrst && grant;  // one cycle after the grant
            if (seq_set0) page <= fifo_head.page;
        end
    end
    // the arbiter grants only a channel that is asking
    a_grant_rq: assert property (@(posedge rst) disable iff (mclk)
        !(channel_pgm_en0 && !want_rq0) && !(channel_pgm_en1 && !want_rq1));
endmodule
`default_nettype wire

//--- cmd_fifo.sv
/* fifo_depth must be a power of two; a write to a full queue is dropped
   sync_rst empties the queue in one cycle */
`timescale 1ns/1ps
`default_nettype none
module cmd_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                             rst,
    input  logic                             mclk,
    input  logic                             sync_rst,
    input  logic                             we,
    input  logic                             re,
    input  logic [ps_pio_pkg::cmd_width-1:0] data_in,
    output logic [ps_pio_pkg::cmd_width-1:0] data_out,
    output logic                             nempty,
    output logic                             half_full
);
    import ps_pio_pkg::*;
    localparam int               ptr_w    = $clog2(fifo_depth);
    localparam logic [ptr_w:0]   full_cnt = (ptr_w + 1)'(fifo_depth);
    localparam logic [ptr_w:0]   half_cnt = (ptr_w + 1)'(fifo_depth / 2);
    logic [cmd_width-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [ptr_w:0]       count;  // entries held
    logic                 do_wr;
    logic                 do_rd;
    assign do_wr     = we && (count != full_cnt);
    assign do_rd     = re && nempty;
    assign nempty    = (count != '0);
    assign half_full = (count >= half_cnt);
    assign data_out  = mem[rd_ptr];  // head entry
    always_ff @(posedge rst) begin
        if (do_wr) mem[wr_ptr] <= data_in;
    end
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            {wr_ptr, rd_ptr, count} <= '0;
        end else if (sync_rst) begin
            {wr_ptr, rd_ptr, count} <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // wraps at the power of two
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (ptr_w + 1)'(do_wr) - (ptr_w + 1)'(do_rd);
        end
    end
    // the sequencer pops only a head that it has already started
    a_no_underrun: assert property (@(posedge rst) disable iff (mclk) re |-> nempty);
endmodule
`default_nettype wire

//--- status_generate.sv
/* address byte while rq is high, then {seq, payload} with rq low, then ad back to 0
   single mode reverts to off and both mode to auto after one message */
`timescale 1ns/1ps
`default_nettype none
module status_generate #(
    parameter logic [7:0] status_reg_addr = 8'h2
) (
    input  logic                                       rst,
    input  logic                                       mclk,
    input  logic                                       we,
    input  ps_pio_pkg::ps_cmd_data_u                   wd,
    input  logic [ps_pio_pkg::status_payload_bits-1:0] status,
    output logic [7:0]                                 ad,
    output logic                                       rq,
    input  logic                                       start
);
    import ps_pio_pkg::*;
    status_mode_t                   mode;
    logic [5:0]                     seq;
    logic [status_payload_bits-1:0] last_sent; // auto mode compares to this
    logic                           data_ph;   // payload byte on ad
    logic                           send;
    assign send = !rq && !data_ph && !we &&
                  (mode == mode_single || mode == mode_both ||
                   (mode == mode_auto && status != last_sent));
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            mode      <= mode_off;
            seq       <= '0;
            last_sent <= '0;
            data_ph   <= 1'b0;
            rq        <= 1'b0;
            ad        <= '0;
        end else begin
            if (we) begin
                mode <= wd.stat.mode;
                seq  <= wd.stat.seq;
            end else if (send && mode == mode_single) begin
                mode <= mode_off;
            end else if (send && mode == mode_both) begin
                mode <= mode_auto;
            end
            data_ph <= rq && start;
            if (send) begin
                rq <= 1'b1;
                ad <= status_reg_addr;
            end else if (rq && start) begin  // address taken downstream
                rq        <= 1'b0;
                ad        <= {seq, status};
                last_sent <= status;
            end else if (data_ph) begin
                ad <= '0;
            end
        end
    end
    // downstream may take several cycles to accept the address byte
    a_ad_hold: assert property (@(posedge rst) disable iff (mclk)
        rq && !start |=> rq && $stable(ad));
endmodule
`default_nettype wire

//--- cmd_deser.sv
/* byte order is addr lo, addr hi, data 0..3 with stb on the first byte
   we pulses one cycle after the sixth byte, only when the masked address matches */
`timescale 1ns/1ps
`default_nettype none
module cmd_deser #(
    parameter logic [15:0] cmd_addr = 16'h100,
    parameter logic [15:0] cmd_mask = 16'h3e0
) (
    input  logic                                  rst,  // system clock
    input  logic                                  mclk, // async reset
    input  logic [7:0]                            ad,
    input  logic                                  stb,
    output logic [ps_pio_pkg::reg_addr_width-1:0] addr,
    output ps_pio_pkg::ps_cmd_data_u              data,
    output logic                                  we
);
    import ps_pio_pkg::*;
    logic [2:0]  cnt;       // bytes taken, 0 when idle
    logic [47:0] sr;        // newest byte enters at the top
    logic [15:0] cur_addr;  // valid once two bytes are in
    logic        addr_hit;
    logic        last_byte;
    assign cur_addr  = sr[47:32];
    assign last_byte = (cnt == 3'd5) && !stb;
    assign data      = ps_cmd_data_u'(sr[47:16]); // d3 ends up in the top byte
    always_ff @(posedge rst) begin
        if (stb || cnt != 3'd0) sr <= {ad, sr[47:8]};
        if (cnt == 3'd2 && !stb) addr <= cur_addr[reg_addr_width-1:0];
    end
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            cnt      <= 3'd0;
            addr_hit <= 1'b0;
            we       <= 1'b0;
        end else begin
            if (stb)               cnt <= 3'd1;  // restart mid-message too
            else if (last_byte)    cnt <= 3'd0;
            else if (cnt != 3'd0)  cnt <= cnt + 3'd1;
            if (cnt == 3'd2 && !stb) begin
                addr_hit <= ((cur_addr ^ cmd_addr) & cmd_mask) == 16'h0;
            end
            we <= last_byte && addr_hit;
        end
    end
    // a message takes six bytes so writes never come back to back
    a_we_single: assert property (@(posedge rst) disable iff (mclk) we |=> !we);
endmodule
`default_nettype wire

//--- ps_pio_pkg.sv
/* widths and encodings shared by the pio channel pair
   one 32-bit command data word is decoded three ways, by register address */
`default_nettype none
package ps_pio_pkg;
    localparam int cmd_width           = 14; // one queued command
    localparam int seq_addr_width      = 10; // sequencer start address
    localparam int page_width          = 2;  // 4 pages per buffer
    localparam int reg_addr_width      = 5;
    localparam int status_payload_bits = 2;
    typedef enum logic [1:0] {
        mode_off    = 2'd0,
        mode_single = 2'd1, // send once
        mode_auto   = 2'd2, // send on payload change
        mode_both   = 2'd3  // send once then auto
    } status_mode_t;
    typedef struct packed {
        logic                      chn;   // 0 = read ddr / 1 = write ddr
        logic                      need;  // urgent request
        logic [page_width-1:0]     page;  // buffer page
        logic [seq_addr_width-1:0] seq_a;
    } ps_cmd_entry_t;
    typedef union packed {
        struct packed {
            logic [17:0]   pad;
            ps_cmd_entry_t entry;
        } cmd;
        struct packed {
            logic [23:0]  pad;
            status_mode_t mode;
            logic [5:0]   seq;  // echoed in the status message
        } stat;
        struct packed {
            logic [29:0] pad;
            logic        en;    // allow new requests
            logic        nrst;  // low flushes queue and requests
        } enable;
    } ps_cmd_data_u;
endpackage
`default_nettype wire
